// File: tb.f
rtl/fetch_pkg.sv
rtl/fetch_line_if.sv
rtl/inst_fifo.sv
rtl/ibuffer.sv
rtl/fetch_sequencer.sv
rtl/fetch_unit.sv
tests/fetch_unit_tb.sv

// File: Makefile
TOP = fetch_unit_tb

all: run

obj_dir/V$(TOP): tb.f $(wildcard rtl/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: tests/fetch_unit_tb.sv
`timescale 1ns/100ps

module fetch_unit_tb import fetch_pkg::*; ();

    logic  clock = 1'b0;
    logic  reset_n;
    logic  redirect;
    addr_t redirect_pc;
    logic  mem_done = 1'b0;
    line_t mem_rdata = '0;
    logic  inst_read;
    logic  stall;
    logic  mem_req;
    addr_t mem_addr;
    logic  inst_valid;
    inst_t inst;
    addr_t inst_pc;
    logic  empty;

    addr_t       req_q[$];          // Requests waiting on the memory model
    addr_t       addr_log[$];       // mem_addr history since the last redirect
    addr_t       mem_base = '0;     // Line being served
    int          mem_delay = 0;
    logic        mem_busy = 1'b0;
    logic [31:0] lcg_state = 32'd80;
    addr_t       exp_pc;            // Next PC the stream must deliver
    int          errors = 0;
    int          failed_tests = 0;

    // 16 entries, so a refill line on top of three queued words fills the FIFO
    fetch_unit #(.FIFO_DEPTH(16), .REFILL_LEVEL(4)) UUT (
        .clock(clock), .reset_n(reset_n), .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_done(mem_done), .mem_rdata(mem_rdata), .inst_read(inst_read), .stall(stall),
        .mem_req(mem_req), .mem_addr(mem_addr), .inst_valid(inst_valid), .inst(inst),
        .inst_pc(inst_pc), .empty(empty)
    );

    always #5 clock = ~clock;  // 10 ns period

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {17'd0, lcg_state[30:16]};  // Upper bits, better spread
    endfunction

    // Word stored at a byte address
    function automatic inst_t word_at(addr_t a);
        return a[31:0] ^ 32'h5A5A0000;
    endfunction

    function automatic line_t line_at(addr_t base);
        line_t l;
        for (int i = 0; i < 16; i++)
            l[i*32 +: 32] = word_at(base + addr_t'(i * 4));
        return l;
    endfunction

    // Request capture, mid-cycle where mem_req is settled
    always @(negedge clock) begin
        if (reset_n && mem_req) begin
            req_q.push_back(mem_addr);
            addr_log.push_back(mem_addr);
        end
    end

    // In-order returns, 1 to 6 cycles after the request
    always @(posedge clock) begin
        #1;
        mem_done = 1'b0;
        if (!mem_busy && req_q.size() > 0) begin
            mem_base  = req_q.pop_front();
            mem_delay = 1 + int'(lcg_next() % 6);
            mem_busy  = 1'b1;
        end
        if (mem_busy) begin
            mem_delay = mem_delay - 1;
            if (mem_delay == 0) begin
                mem_done  = 1'b1;
                mem_rdata = line_at(mem_base);
                mem_busy  = 1'b0;
            end
        end
    end

    task automatic report_mismatch(string name, string what, logic [63:0] exp, logic [63:0] act);
        $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, exp, act);
        errors++;
    endtask

    task automatic finish_test(string name, int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
            failed_tests++;
        end
    endtask

    // Redirect at once, or lag cycles after the next line request when lag is not negative
    task automatic redirect_to(string name, addr_t pc, int lag);
        int waited;
        waited = 0;
        if (lag >= 0) begin
            while (!mem_req && waited < 200) begin
                @(posedge clock);
                #1;
                waited++;
            end
            if (!mem_req) begin
                $display("%s: timed out waiting for a line request", name);
                errors++;
            end
            repeat (lag) begin
                @(posedge clock);  // Sequencer now waits on that line
                #1;
            end
        end
        redirect    = 1'b1;
        redirect_pc = pc;
        @(posedge clock);
        #1;
        redirect = 1'b0;
        exp_pc   = pc;
        addr_log.delete();
        assert (empty) else report_mismatch(name, "empty", 64'd1, 64'(empty));
    endtask

    // Collect n instructions, each checked against the consecutive word rule
    task automatic collect(string name, int n, bit rough);
        int   got;
        int   cycles;
        int   stall_left;
        int   pause_left;
        bit   paused;
        logic prev_stall;
        logic prev_read;
        logic next_stall;
        logic next_read;
        got        = 0;
        cycles     = 0;
        stall_left = 0;
        pause_left = 0;
        paused     = 1'b0;
        prev_stall = stall;
        prev_read  = inst_read;
        while (got < n && cycles < 20 * n + 200) begin
            @(negedge clock);
            if (inst_valid) begin
                assert (inst_pc == exp_pc)
                    else report_mismatch(name, "inst_pc", 64'(exp_pc), 64'(inst_pc));
                assert (inst == word_at(exp_pc))
                    else report_mismatch(name, "inst", 64'(word_at(exp_pc)), 64'(inst));
                assert (prev_read && !prev_stall) else begin
                    $display("%s: inst_valid after a stalled or idle read cycle", name);
                    errors++;
                end
                exp_pc = exp_pc + addr_t'(4);
                got++;
            end
            prev_stall = stall;
            prev_read  = inst_read;
            next_stall = 1'b0;
            next_read  = 1'b1;
            if (rough) begin
                if (stall_left == 0 && lcg_next() % 4 == 0)
                    stall_left = 1 + int'(lcg_next() % 6);  // New stall stretch
                if (stall_left > 0) begin
                    next_stall = 1'b1;
                    stall_left--;
                end
                if (got >= 12 && !paused && mem_req && !empty) begin
                    paused     = 1'b1;  // Refill line heading for a non-empty FIFO
                    pause_left = 40;  // Long enough to fill the FIFO
                end
                if (pause_left > 0) begin
                    next_read = 1'b0;
                    pause_left--;
                    if (pause_left == 0) begin
                        assert (!empty)
                            else report_mismatch(name, "empty", 64'd0, 64'(empty));
                    end
                end
            end
            @(posedge clock);
            #1;
            stall     = next_stall;
            inst_read = next_read;
            cycles++;
        end
        stall     = 1'b0;
        inst_read = 1'b1;
        if (got < n) begin
            $display("%s: timed out with %0d of %0d instructions", name, got, n);
            errors++;
        end
    endtask

    task automatic aligned_start();
        int e0;
        e0 = errors;
        redirect_to("aligned_start", 48'h0000_1000_0400, -1);
        collect("aligned_start", 16, 1'b0);
        finish_test("aligned_start", e0);
    endtask

    task automatic unaligned_start();
        int e0;
        e0 = errors;
        redirect_to("unaligned_start", 48'h0000_2000_0024, -1);  // Slot 9
        collect("unaligned_start", 20, 1'b0);                     // Crosses into next line
        finish_test("unaligned_start", e0);
    endtask

    task automatic continuous_refill();
        int    e0;
        addr_t base;
        e0   = errors;
        base = 48'h0001_3000_0000;
        redirect_to("continuous_refill", base, -1);
        collect("continuous_refill", 60, 1'b0);
        assert (addr_log.size() >= 4) else begin
            $display("continuous_refill: only %0d line requests seen", addr_log.size());
            errors++;
        end
        foreach (addr_log[i])
            assert (addr_log[i] == base + addr_t'(64 * i))
                else report_mismatch("continuous_refill", "mem_addr",
                                     64'(base + addr_t'(64 * i)), 64'(addr_log[i]));
        finish_test("continuous_refill", e0);
    endtask

    task automatic stall_backpressure();
        int e0;
        e0 = errors;
        redirect_to("stall_backpressure", 48'h0000_4000_0108, -1);
        collect("stall_backpressure", 80, 1'b1);
        finish_test("stall_backpressure", e0);
    endtask

    task automatic flush_on_redirect();
        int e0;
        e0 = errors;
        redirect_to("flush_redirect", 48'h0000_5000_0000, -1);
        redirect_to("flush_redirect", 48'h0000_6000_0034, 0);  // Same cycle as the first request
        collect("flush_redirect", 24, 1'b0);
        redirect_to("flush_redirect", 48'h0002_7000_0010, 1);  // Mid-stream refill in flight
        collect("flush_redirect", 24, 1'b0);
        redirect_to("flush_redirect", 48'h0000_8000_003C, -1);  // Last slot of a line
        collect("flush_redirect", 8, 1'b0);
        finish_test("flush_redirect", e0);
    endtask

    initial begin
        reset_n     = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        inst_read   = 1'b0;
        stall       = 1'b0;
        exp_pc      = '0;
        repeat (5) @(posedge clock);
        #1;
        reset_n   = 1'b1;
        inst_read = 1'b1;
        aligned_start();
        unaligned_start();
        continuous_refill();
        stall_backpressure();
        flush_on_redirect();
        $display("5 tests run, %0d failed, %0d failed checks", failed_tests, errors);
        if (failed_tests == 0 && errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit import fetch_pkg::*; #(
    parameter int FIFO_DEPTH   = 24,
    parameter int REFILL_LEVEL = 4
) (
    input  logic  clock,
    input  logic  reset_n,
    input  logic  redirect,     // Pulse, new PC and flush
    input  addr_t redirect_pc,
    input  logic  mem_done,     // Line return strobe
    input  line_t mem_rdata,
    input  logic  inst_read,    // Level
    input  logic  stall,        // Level
    output logic  mem_req,      // Line request pulse
    output addr_t mem_addr,
    output logic  inst_valid,
    output inst_t inst,
    output addr_t inst_pc,
    output logic  empty
);

    fetch_line_if line_bus ();

    logic refill;  // Buffer asks for the next line

    fetch_sequencer u_seq (
        .clock       (clock),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .refill      (refill),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata),
        .line        (line_bus)
    );

    ibuffer #(
        .FIFO_DEPTH   (FIFO_DEPTH),
        .REFILL_LEVEL (REFILL_LEVEL)
    ) u_ibuf (
        .clock       (clock),
        .reset_n     (reset_n),
        .clear       (redirect),   // Redirect flushes the queue
        .line        (line_bus),
        .fifo_read   (inst_read),
        .stall       (stall),
        .instr_valid (inst_valid),
        .inst_out    (inst),
        .pc_out      (inst_pc),
        .fetch_inst  (refill),
        .fifo_empty  (empty)
    );

endmodule

// File: rtl/fetch_sequencer.sv
`timescale 1ns/100ps

module fetch_sequencer import fetch_pkg::*; (
    input  logic          clock,
    input  logic          reset_n,
    input  logic          redirect,
    input  addr_t         redirect_pc,
    input  logic          refill,       // From buffer
    output logic          mem_req,
    output addr_t         mem_addr,
    input  logic          mem_done,
    input  line_t         mem_rdata,
    fetch_line_if.seq     line
);

    typedef enum logic {IDLE, WAIT} state_t;

    state_t     state;
    addr_t      fetch_pc;        // Line-aligned
    slot_t      pend_slot;       // Start slot for the outstanding line
    logic       refill_pending;  // Request to serve once IDLE
    logic [1:0] stale_cnt;       // Canceled returns still to come
    logic       accept;
    logic       drop_old;
    logic       cancel;

    assign mem_req  = (state == IDLE) && refill_pending;
    assign mem_addr = fetch_pc;

    // Stale returns arrive first, in request order
    assign accept   = mem_done && (state == WAIT) && (stale_cnt == '0) && !redirect;
    assign drop_old = mem_done && (stale_cnt != '0);
    // A request leaving in the redirect cycle is stale as well
    assign cancel   = redirect && (mem_req || (state == WAIT && !(mem_done && stale_cnt == '0)));

    assign line.line_done  = accept;
    assign line.line_data  = mem_rdata;
    assign line.line_pc    = fetch_pc;
    assign line.start_slot = pend_slot;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state          <= IDLE;
            fetch_pc       <= '0;  // Reset PC
            pend_slot      <= '0;
            refill_pending <= 1'b0;
            stale_cnt      <= '0;
        end else begin
            case ({cancel, drop_old})
                2'b10:   stale_cnt <= stale_cnt + 1'b1;
                2'b01:   stale_cnt <= stale_cnt - 1'b1;
                default: stale_cnt <= stale_cnt;
            endcase
            if (redirect) begin
                fetch_pc       <= redirect_pc & ~addr_t'(LINE_BYTES - 1);
                pend_slot      <= slot_t'(redirect_pc[5:2]);
                refill_pending <= 1'b1;  // mem_req next cycle
                state          <= IDLE;
            end else begin
                case (state)
                    IDLE: begin
                        if (refill_pending)
                            state <= WAIT;      // Request goes out this cycle
                        refill_pending <= refill;
                    end
                    WAIT: begin
                        if (refill)
                            refill_pending <= 1'b1;  // Served after the return
                        if (accept) begin
                            state     <= IDLE;
                            fetch_pc  <= fetch_pc + addr_t'(LINE_BYTES);
                            pend_slot <= '0;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // One request per line, none while waiting on a return
    a_single_req: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req && !redirect |=> !mem_req until (line.line_done || redirect));

endmodule

// File: rtl/ibuffer.sv
`timescale 1ns/100ps

module ibuffer import fetch_pkg::*; #(
    parameter int FIFO_DEPTH   = 24,
    parameter int REFILL_LEVEL = 4
) (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              clear,        // Flush on redirect
    fetch_line_if.ibuf        line,
    input  logic              fifo_read,
    input  logic              stall,
    output logic              instr_valid,
    output inst_t             inst_out,
    output addr_t             pc_out,
    output logic              fetch_inst,   // Refill pulse to sequencer
    output logic              fifo_empty
);

    entry_t line_split [LINE_SLOTS];  // Current line_done fields, per slot
    entry_t line_buf [LINE_SLOTS];    // Latched line
    slot_t  wr_idx;                   // Next slot to push
    logic   writing;                  // Line being written into FIFO
    logic   line_wait;                // A requested line is still on its way
    logic   fifo_wr;
    logic   fifo_full;
    count_t fifo_count;
    count_t count_prev;
    entry_t fifo_out;
    logic   can_fetch;
    logic   count_fall;
    logic   refill_cond;

    inst_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock      (clock),
        .reset_n    (reset_n),
        .clear      (clear),
        .data_in    (line_buf[wr_idx]),
        .write_en   (fifo_wr),
        .read_en    (fifo_read),
        .stall      (stall),
        .data_out   (fifo_out),
        .data_valid (instr_valid),
        .empty      (fifo_empty),
        .full       (fifo_full),
        .count      (fifo_count)
    );

    assign inst_out = entry_inst(fifo_out);
    assign pc_out   = entry_pc(fifo_out);

    // Split the line, slot PC is base + 4*slot
    always_comb begin
        for (int i = 0; i < LINE_SLOTS; i++) begin
            line_split[i] = make_entry(line.line_data[i*32 +: 32],
                                       line.line_pc + addr_t'(i * 4));
        end
    end

    always_ff @(posedge clock) begin
        if (line.line_done)
            line_buf <= line_split;
    end

    assign fifo_wr     = writing && !fifo_full;  // Pause while full
    assign can_fetch   = !writing && !line_wait && !line.line_done;
    assign count_fall  = (count_prev == count_t'(REFILL_LEVEL)) &&
                         (fifo_count == count_t'(REFILL_LEVEL - 1));
    assign refill_cond = count_fall || fifo_empty;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            writing    <= 1'b0;
            wr_idx     <= '0;
            line_wait  <= 1'b0;  // Empty after reset, first refill fetches PC 0
            fetch_inst <= 1'b0;
            count_prev <= '0;
        end else if (clear) begin
            writing    <= 1'b0;
            wr_idx     <= '0;
            line_wait  <= 1'b1;  // Redirect issues its own line request
            fetch_inst <= 1'b0;
            count_prev <= '0;
        end else begin
            count_prev <= fifo_count;
            fetch_inst <= can_fetch && refill_cond;
            if (can_fetch && refill_cond)
                line_wait <= 1'b1;
            if (line.line_done) begin
                writing   <= 1'b1;             // Start at the PC's own word
                wr_idx    <= line.start_slot;
                line_wait <= 1'b0;
            end else if (fifo_wr) begin
                if (wr_idx == slot_t'(LINE_SLOTS - 1))
                    writing <= 1'b0;           // Slot 15 done
                else
                    wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    // Full FIFO holds the write slot, nothing skipped
    a_write_pause: assert property (@(posedge clock) disable iff (!reset_n)
        writing && fifo_full && !clear && !line.line_done |=> writing && $stable(wr_idx));

    // Sequencer never returns a line on top of one still being written
    a_one_line: assert property (@(posedge clock) disable iff (!reset_n)
        line.line_done |-> !writing);

endmodule

// File: rtl/inst_fifo.sv
`timescale 1ns/100ps

module inst_fifo import fetch_pkg::*; #(
    parameter int FIFO_DEPTH = 24
) (
    input  logic   clock,
    input  logic   reset_n,
    input  logic   clear,       // Flush, one cycle
    input  entry_t data_in,
    input  logic   write_en,
    input  logic   read_en,
    input  logic   stall,       // Freezes pops only
    output entry_t data_out,    // Registered
    output logic   data_valid,
    output logic   empty,
    output logic   full,
    output count_t count
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    entry_t mem [FIFO_DEPTH];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    logic   push;
    logic   pop;

    // Wrap at FIFO_DEPTH, depth need not be a power of two
    function automatic ptr_t ptr_next(ptr_t p);
        return (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == count_t'(FIFO_DEPTH));
    assign push  = write_en && !full;
    assign pop   = read_en && !empty && !stall;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            data_valid <= 1'b0;
        end else if (clear) begin
            wr_ptr     <= '0;  // Pointers back to start
            rd_ptr     <= '0;
            count      <= '0;
            data_valid <= 1'b0;  // Drop any word in flight
        end else begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            data_valid <= pop;  // One cycle per pop
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push+pop
            endcase
        end
    end

    // Storage and output word
    always_ff @(posedge clock) begin
        if (push && !clear)
            mem[wr_ptr] <= data_in;
        if (pop)
            data_out <= mem[rd_ptr];
    end

    // Occupancy bound
    a_count_bound: assert property (@(posedge clock) disable iff (!reset_n)
        count <= count_t'(FIFO_DEPTH));

    // A valid word always comes from a pop one cycle earlier
    a_valid_after_pop: assert property (@(posedge clock) disable iff (!reset_n)
        data_valid |-> $past(pop && !clear));

endmodule

// File: rtl/fetch_line_if.sv
`timescale 1ns/100ps

// Returned fetch line, sequencer to buffer
// All fields only valid in the line_done cycle
interface fetch_line_if import fetch_pkg::*; ();

    logic  line_done;   // One-cycle strobe
    line_t line_data;   // Raw 512-bit line
    addr_t line_pc;     // Line-aligned base
    slot_t start_slot;  // First slot to write

    modport seq (
        output line_done,
        output line_data,
        output line_pc,
        output start_slot
    );

    modport ibuf (
        input line_done,
        input line_data,
        input line_pc,
        input start_slot
    );

endinterface

// File: rtl/fetch_pkg.sv
package fetch_pkg;

    typedef logic [47:0]  addr_t;   // Instruction address
    typedef logic [31:0]  inst_t;   // One instruction word
    typedef logic [511:0] line_t;   // Sixteen words, slot i at bits 32i+31:32i
    typedef logic [3:0]   slot_t;   // Word slot within a line
    typedef logic [79:0]  entry_t;  // {inst, pc}
    typedef logic [4:0]   count_t;  // FIFO occupancy

    localparam int LINE_SLOTS = 16;
    localparam int LINE_BYTES = 64;

    // Entry layout, instruction on top and PC below
    function automatic entry_t make_entry(inst_t inst, addr_t pc);
        return {inst, pc};
    endfunction

    function automatic inst_t entry_inst(entry_t e);
        return e[$bits(entry_t)-1 -: $bits(inst_t)];
    endfunction

    function automatic addr_t entry_pc(entry_t e);
        return e[$bits(addr_t)-1:0];
    endfunction

endpackage
